// ==== source/clct_pkg.sv ====
`default_nettype none

package clct_pkg;

  // ------------------------------------------------------------------------
  // field widths of the pattern finder output
  // ------------------------------------------------------------------------

  // five strip groups feed the final sorter
  localparam int NGRP    = 5;
  // pattern id, bits 6..1 sortable and bit 0 is bend direction
  localparam int MXPATB  = 7;
  // key half-strip within one group
  localparam int MXKEYB  = 5;
  // full key half-strip across the chamber
  localparam int MXKEYBX = 8;
  // quarter-strip subkey
  localparam int MXXKYB  = 10;
  // comparator code offset from the ccLUT fit
  localparam int MXOFFSB = 4;
  localparam int MXQLTB  = 6;
  localparam int MXBNDB  = 5;
  // comparator carry word
  localparam int MXPATC  = 12;
  // sort key is either pat[6:1] or the fit quality
  localparam int SORTB   = 6;

  // ------------------------------------------------------------------------
  // offset word
  // ------------------------------------------------------------------------

  // split view of the offset
  // hs_adj shifts the half-strip, qs places the quarter-strip
  typedef struct packed {
    logic [1:0] hs_adj;
    logic [1:0] qs;
  } clct_offs_fld_t;

  // same 4 bits, read raw or as two fields
  typedef union packed {
    logic [MXOFFSB-1:0] raw;
    clct_offs_fld_t     fld;
  } clct_offs_u;

  // ------------------------------------------------------------------------
  // candidate and result
  // ------------------------------------------------------------------------

  // one group candidate, 39 bits
  typedef struct packed {
    logic [MXPATB-1:0] pat;
    logic [MXKEYB-1:0] key;
    clct_offs_u        offs;
    logic [MXQLTB-1:0] qlt;
    logic [MXBNDB-1:0] bend;
    logic [MXPATC-1:0] carry;
  } clct_cand_t;

  typedef clct_cand_t [NGRP-1:0] clct_cand_arr_t;

  typedef logic [NGRP-1:0][SORTB-1:0] clct_sort_arr_t;

  // best pattern with full key and subkey, 48 bits
  typedef struct packed {
    logic [MXPATB-1:0]  pat;
    logic [MXKEYBX-1:0] key;
    logic [MXXKYB-1:0]  subkey;
    logic [MXQLTB-1:0]  qlt;
    logic [MXBNDB-1:0]  bend;
    logic [MXPATC-1:0]  carry;
  } clct_best_t;

endpackage

`default_nettype wire

// ==== source/clct_cand_capture.sv ====
`default_nettype none

module clct_cand_capture
  import clct_pkg::*;
#(
  // 1 sorts on fit quality, 0 sorts on pattern id
  parameter logic SORT_ON_QLT = 1'b0
)
(
  input  logic            clock,
  input  logic            rst,
  input  logic            cand_valid,
  input  clct_cand_arr_t  cand,
  input  logic [NGRP-1:0] group_mask,
  output logic            cap_valid,
  output clct_cand_arr_t  cap_cand,
  output clct_sort_arr_t  cap_sort
);

  // candidates after masking
  clct_cand_arr_t cand_blank;
  // sort keys built from the masked candidates
  clct_sort_arr_t sort_nxt;

  // ------------------------------------------------------------------------
  // blanking and sort key selection
  // ------------------------------------------------------------------------

  always_comb
  begin
    for (int g = 0; g < NGRP; g++)
    begin
      // masked group becomes an all-zero candidate
      if (group_mask[g])
        cand_blank[g] = '0;
      else
        cand_blank[g] = cand[g];

      // lsb of the pattern id only gives bend direction so it is dropped
      if (SORT_ON_QLT)
        sort_nxt[g] = cand_blank[g].qlt;
      else
        sort_nxt[g] = cand_blank[g].pat[MXPATB-1:1];
    end
  end

  // ------------------------------------------------------------------------
  // capture registers
  // ------------------------------------------------------------------------

  // strobe follows cand_valid by one clock
  always_ff @(posedge clock)
  begin
    if (rst)
      cap_valid <= 1'b0;
    else
      cap_valid <= cand_valid;
  end

  // payload loads only on a strobe
  // sort keys are registered too so the compare tree starts from flops
  always_ff @(posedge clock)
  begin
    if (cand_valid)
    begin
      cap_cand <= cand_blank;
      cap_sort <= sort_nxt;
    end
  end

endmodule

`default_nettype wire

// ==== source/best_1of5_cclut.sv ====
`default_nettype none

module best_1of5_cclut
  import clct_pkg::*;
(
  input  clct_cand_arr_t cap_cand,
  input  clct_sort_arr_t cap_sort,
  output clct_best_t     sel
);

  // group number takes the bits above the in-group key
  localparam int GRPB = MXKEYBX - MXKEYB;

  // winning group index
  logic [GRPB-1:0]    win_grp;
  // winning candidate
  clct_cand_t         win;
  // quarter-strip carry into the half-strip
  logic               qs_carry;
  logic [MXKEYBX-1:0] key_full;
  logic [1:0]         qs_next;

  // ------------------------------------------------------------------------
  // priority compare tree
  // ------------------------------------------------------------------------

  // a group wins only when strictly above every lower group
  // higher groups are tested later and override, so ties fall
  // to the lowest group holding the maximum
  always_comb
  begin
    logic top_ok;
    win_grp = '0;
    for (int g = 1; g < NGRP; g++)
    begin
      top_ok = 1'b1;
      for (int h = 0; h < g; h++)
      begin
        if (!(cap_sort[g] > cap_sort[h]))
          top_ok = 1'b0;
      end
      if (top_ok)
        win_grp = GRPB'(g);
    end
  end

  // group 0 is the default winner
  assign win = cap_cand[win_grp];

  // ------------------------------------------------------------------------
  // key correction from the ccLUT offset
  // ------------------------------------------------------------------------

  // bit pair view of the offset, both qs bits set
  // pushes the key up by one more half-strip
  assign qs_carry = win.offs.raw[1] & win.offs.raw[0];

  // full key = {group, key} + hs_adj + carry - 2
  // all terms are 8 bits so the result wraps mod 256
  always_comb
  begin
    key_full = {win_grp, win.key};
    key_full = key_full + MXKEYBX'(win.offs.fld.hs_adj);
    key_full = key_full + MXKEYBX'(qs_carry);
    key_full = key_full - MXKEYBX'(2);
  end

  // quarter-strip position shifted by one, wraps in 2 bits
  assign qs_next = win.offs.fld.qs + 2'd1;

  // ------------------------------------------------------------------------
  // selected result
  // ------------------------------------------------------------------------

  always_comb
  begin
    sel.pat    = win.pat;
    sel.key    = key_full;
    // subkey is the full key with the quarter-strip below it
    sel.subkey = {key_full, qs_next};
    sel.qlt    = win.qlt;
    sel.bend   = win.bend;
    sel.carry  = win.carry;
  end

endmodule

`default_nettype wire

// ==== source/clct_best_out.sv ====
`default_nettype none

module clct_best_out
  import clct_pkg::*;
#(
  // lowest fit quality that is reported
  parameter logic [MXQLTB-1:0] MIN_QLT = 6'd1
)
(
  input  logic       clock,
  input  logic       rst,
  input  logic       cap_valid,
  input  clct_best_t sel,
  output logic       best_valid,
  output clct_best_t best
);

  // winner passes the quality cut
  logic qlt_ok;
  // a result is reported this clock
  logic take;

  // ------------------------------------------------------------------------
  // quality gate
  // ------------------------------------------------------------------------

  assign qlt_ok = (sel.qlt >= MIN_QLT);
  assign take   = cap_valid & qlt_ok;

  // ------------------------------------------------------------------------
  // output registers
  // ------------------------------------------------------------------------

  // one-clock strobe per accepted winner
  always_ff @(posedge clock)
  begin
    if (rst)
      best_valid <= 1'b0;
    else
      best_valid <= take;
  end

  // low quality winners leave the last reported result in place
  always_ff @(posedge clock)
  begin
    if (take)
      best <= sel;
  end

endmodule

`default_nettype wire

// ==== source/clct_best_top.sv ====
`default_nettype none

module clct_best_top
  import clct_pkg::*;
#(
  parameter logic              SORT_ON_QLT = 1'b0,
  parameter logic [MXQLTB-1:0] MIN_QLT     = 6'd1
)
(
  input  logic            clock,
  input  logic            rst,
  input  logic            cand_valid,
  input  clct_cand_arr_t  cand,
  input  logic [NGRP-1:0] group_mask,
  output logic            best_valid,
  output clct_best_t      best
);

  // capture stage to selector
  logic           cap_valid;
  clct_cand_arr_t cap_cand;
  clct_sort_arr_t cap_sort;
  // combinational winner, aligned with cap_valid
  clct_best_t     sel;

  // ------------------------------------------------------------------------
  // stage 1 registers and masks the five groups
  // ------------------------------------------------------------------------

  clct_cand_capture #(
    .SORT_ON_QLT (SORT_ON_QLT)
  ) cap0 (
    .clock      (clock),
    .rst        (rst),
    .cand_valid (cand_valid),
    .cand       (cand),
    .group_mask (group_mask),
    .cap_valid  (cap_valid),
    .cap_cand   (cap_cand),
    .cap_sort   (cap_sort)
  );

  // ------------------------------------------------------------------------
  // stage 2 picks best 1 of 5 and forms key and subkey
  // ------------------------------------------------------------------------

  best_1of5_cclut sel0 (
    .cap_cand (cap_cand),
    .cap_sort (cap_sort),
    .sel      (sel)
  );

  // output register with quality cut
  clct_best_out #(
    .MIN_QLT (MIN_QLT)
  ) out0 (
    .clock      (clock),
    .rst        (rst),
    .cap_valid  (cap_valid),
    .sel        (sel),
    .best_valid (best_valid),
    .best       (best)
  );

endmodule

`default_nettype wire

// ==== tb/clct_best_assert.sv ====
`default_nettype none

module clct_best_assert
  import clct_pkg::*;
#(
  parameter logic [MXQLTB-1:0] MIN_QLT = 6'd1
)
(
  input logic              clock,
  input logic              rst,
  input logic              cand_valid,
  input logic              best_valid,
  input clct_best_t        best,
  // quality of the combinational winner one cycle after capture
  input logic [MXQLTB-1:0] sel_qlt
);

  timeunit 1ns;
  timeprecision 1ps;

  // number of assertion failures so far
  int fail_count = 0;

  // strobe stays low once reset has been seen on an edge
  a_reset_quiet: assert property (@(posedge clock) rst ##1 rst |-> !best_valid)
    else
    begin
      fail_count = fail_count + 1;
      $error("best_valid high during reset");
    end

  a_min_qlt: assert property (@(posedge clock) disable iff (rst)
    best_valid |-> best.qlt >= MIN_QLT)
    else
    begin
      fail_count = fail_count + 1;
      $error("best_valid with quality below the minimum");
    end

  // accepted winner shows up exactly two edges after its strobe
  a_latency: assert property (@(posedge clock) disable iff (rst)
    cand_valid ##1 (sel_qlt >= MIN_QLT) |=> best_valid)
    else
    begin
      fail_count = fail_count + 1;
      $error("best_valid missing two cycles after cand_valid");
    end

endmodule

bind clct_best_top clct_best_assert #(
  .MIN_QLT (MIN_QLT)
) chk0 (
  .clock      (clock),
  .rst        (rst),
  .cand_valid (cand_valid),
  .best_valid (best_valid),
  .best       (best),
  .sel_qlt    (sel.qlt)
);

`default_nettype wire

// ==== tb/tb_clct_best.sv ====
`default_nettype none

module tb_clct_best
  import clct_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic              SORT_ON_QLT = 1'b0;
  localparam logic [MXQLTB-1:0] MIN_QLT     = 6'd1;
  // cycles allowed for the pipeline to drain
  localparam int                TIMEOUT     = 20;

  // one table row with five candidates and the expected outcome
  typedef struct packed {
    clct_cand_arr_t     cand;
    logic [NGRP-1:0]    mask;
    logic               b2b;
    logic               ev;
    logic [2:0]         eg;
    logic [MXKEYBX-1:0] ek;
    logic [MXXKYB-1:0]  es;
  } entry_t;

  // result due in a given cycle
  typedef struct packed {
    logic        ev;
    logic [31:0] due;
    clct_best_t  exp;
  } pend_t;

  logic            clock = 1'b0;
  logic            rst;
  logic            cand_valid;
  clct_cand_arr_t  cand;
  logic [NGRP-1:0] group_mask;
  logic            best_valid;
  clct_best_t      best;

  entry_t          tbl[$];
  pend_t           pend_q[$];
  // scratch candidate set while the table is built
  clct_cand_arr_t  work;
  // last accepted winner, best must keep it across suppressed sets
  clct_best_t      held;
  logic [31:0]     cyc;
  integer          seed;

  clct_best_top #(
    .SORT_ON_QLT (SORT_ON_QLT),
    .MIN_QLT     (MIN_QLT)
  ) dut0 (
    .clock      (clock),
    .rst        (rst),
    .cand_valid (cand_valid),
    .cand       (cand),
    .group_mask (group_mask),
    .best_valid (best_valid),
    .best       (best)
  );

  // 40 ns period
  always #20 clock = ~clock;

  // ------------------------------------------------------------------------
  // checking
  // ------------------------------------------------------------------------

  task automatic abort_run(string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(string name, logic [47:0] exp, logic [47:0] act);
    if (exp !== act)
      abort_run($sformatf("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act));
  endtask

  // bound checker on the DUT ports
  always @(dut0.chk0.fail_count)
  begin
    if (dut0.chk0.fail_count != 0)
      abort_run("a concurrent assertion on the DUT ports failed");
  end

  // advance to 2 ns past the edge, then sample and drive
  // a pending result must show up exactly in its due cycle
  task automatic next_cycle();
    pend_t p;
    @(posedge clock);
    #2;
    cyc = cyc + 1;
    if (pend_q.size() > 0 && pend_q[0].due == cyc)
    begin
      p = pend_q.pop_front();
      check_value("best_valid", 48'(p.ev), 48'(best_valid));
      if (p.ev)
      begin
        check_value("best.key", 48'(p.exp.key), 48'(best.key));
        check_value("best.subkey", 48'(p.exp.subkey), 48'(best.subkey));
        check_value("best", p.exp, best);
        held = p.exp;
      end
      else
        check_value("best", held, best);
    end
    else if (!rst)
      check_value("best_valid", 48'd0, 48'(best_valid));
  endtask

  task automatic wait_results();
    int n;
    n = 0;
    while (pend_q.size() > 0)
    begin
      if (n >= TIMEOUT)
        abort_run("timeout, best_valid never arrived for a pending candidate set");
      else
      begin
        next_cycle();
        n++;
      end
    end
  endtask

  // ------------------------------------------------------------------------
  // reference model and stimulus table
  // ------------------------------------------------------------------------

  function automatic logic [SORTB-1:0] rank_of(clct_cand_t c);
    if (SORT_ON_QLT)
      return c.qlt;
    else
      return c.pat[MXPATB-1:1];
  endfunction

  // scan upward, strictly greater replaces, so the lowest tied group stays
  function automatic entry_t predict(entry_t e);
    clct_cand_arr_t c;
    clct_cand_t     w;
    int             g_best;
    int             k;
    int             qn;
    for (int g = 0; g < NGRP; g++)
      c[g] = e.mask[g] ? clct_cand_t'('0) : e.cand[g];
    g_best = 0;
    for (int g = 1; g < NGRP; g++)
      if (rank_of(c[g]) > rank_of(c[g_best]))
        g_best = g;
    w = c[g_best];
    k = 32 * g_best + int'(w.key) + int'(w.offs.fld.hs_adj) - 2;
    if (w.offs.fld.qs == 2'd3)
      k = k + 1;
    k = (k + 256) % 256;
    qn = (int'(w.offs.fld.qs) + 1) % 4;
    e.ev = (w.qlt >= MIN_QLT);
    e.eg = 3'(g_best);
    e.ek = 8'(k);
    e.es = 10'(4 * k + qn);
    return e;
  endfunction

  // bend and carry tag the group so the winner can be told apart
  function automatic clct_cand_t make_cand(int g, logic [6:0] pat, logic [4:0] key,
                                           logic [3:0] offs, logic [5:0] qlt);
    clct_cand_t c;
    c.pat      = pat;
    c.key      = key;
    c.offs.raw = offs;
    c.qlt      = qlt;
    c.bend     = 5'(3 * g + 1);
    c.carry    = 12'(12'h5a0 + g);
    return c;
  endfunction

  // low rank everywhere and offset 8 leaves the key unchanged
  task automatic load_defaults();
    for (int g = 0; g < NGRP; g++)
      work[g] = make_cand(g, 7'h02, 5'd4, 4'h8, 6'd5);
  endtask

  task automatic add_entry(logic [4:0] mask, logic b2b, logic ev, int eg,
                           logic [7:0] ek, logic [9:0] es);
    entry_t e;
    e.cand = work;
    e.mask = mask;
    e.b2b  = b2b;
    e.ev   = ev;
    e.eg   = 3'(eg);
    e.ek   = ek;
    e.es   = es;
    tbl.push_back(e);
  endtask

  task automatic build_table();
    // clear winner in each group position
    for (int g = 0; g < NGRP; g++)
    begin
      load_defaults();
      work[g] = make_cand(g, 7'h40, 5'd10, 4'h8, 6'd20);
      add_entry(5'h00, 0, 1, g, 8'(32 * g + 10), 10'(4 * (32 * g + 10) + 1));
    end
    // ties where pat 40 and 41 rank the same
    load_defaults();
    work[1] = make_cand(1, 7'h40, 5'd7, 4'h8, 6'd9);
    work[3] = make_cand(3, 7'h41, 5'd7, 4'h8, 6'd9);
    add_entry(5'h00, 0, 1, 1, 8'd39, 10'd157);
    load_defaults();
    add_entry(5'h00, 0, 1, 0, 8'd4, 10'd17);
    // offset corrections in group 2 around base key 80
    load_defaults();
    work[2] = make_cand(2, 7'h40, 5'd16, 4'h0, 6'd30);
    add_entry(5'h00, 0, 1, 2, 8'd78, 10'd313);
    work[2].offs.raw = 4'h5;
    add_entry(5'h00, 0, 1, 2, 8'd79, 10'd318);
    work[2].offs.raw = 4'he;
    add_entry(5'h00, 0, 1, 2, 8'd81, 10'd327);
    work[2].offs.raw = 4'hb;
    add_entry(5'h00, 0, 1, 2, 8'd81, 10'd324);
    // wrap below zero in group 0
    load_defaults();
    work[0] = make_cand(0, 7'h40, 5'd0, 4'h0, 6'd30);
    add_entry(5'h00, 0, 1, 0, 8'd254, 10'd1017);
    // top of the range in group 4
    load_defaults();
    work[4] = make_cand(4, 7'h40, 5'd31, 4'hf, 6'd30);
    add_entry(5'h00, 0, 1, 4, 8'd161, 10'd644);
    // masked best group loses to group 2
    load_defaults();
    work[4] = make_cand(4, 7'h7e, 5'd3, 4'h8, 6'd40);
    work[2] = make_cand(2, 7'h30, 5'd9, 4'h8, 6'd12);
    add_entry(5'h10, 0, 1, 2, 8'd73, 10'd293);
    // everything masked or zero quality gives no strobe
    add_entry(5'h1f, 0, 0, 0, 8'd254, 10'd1017);
    load_defaults();
    work[3] = make_cand(3, 7'h50, 5'd5, 4'h8, 6'd0);
    add_entry(5'h00, 0, 0, 3, 8'd101, 10'd405);
    // back-to-back burst with a suppressed set inside
    load_defaults();
    work[1] = make_cand(1, 7'h60, 5'd2, 4'h8, 6'd7);
    add_entry(5'h00, 0, 1, 1, 8'd34, 10'd137);
    load_defaults();
    work[3] = make_cand(3, 7'h60, 5'd20, 4'hc, 6'd8);
    add_entry(5'h00, 1, 1, 3, 8'd117, 10'd469);
    load_defaults();
    work[0] = make_cand(0, 7'h60, 5'd30, 4'h7, 6'd9);
    add_entry(5'h00, 1, 1, 0, 8'd30, 10'd120);
    load_defaults();
    work[2] = make_cand(2, 7'h60, 5'd1, 4'h8, 6'd0);
    add_entry(5'h00, 1, 0, 2, 8'd65, 10'd261);
    load_defaults();
    add_entry(5'h00, 1, 1, 0, 8'd4, 10'd17);
  endtask

  task automatic add_random_entries(int count);
    entry_t      e;
    logic [63:0] rnd;
    for (int n = 0; n < count; n++)
    begin
      for (int g = 0; g < NGRP; g++)
      begin
        rnd = {$random(seed), $random(seed)};
        e.cand[g] = rnd[38:0];
      end
      // each group masked about one time in four
      e.mask = 5'($random(seed) & $random(seed));
      e.b2b  = 1'($random(seed));
      tbl.push_back(predict(e));
    end
  endtask

  task automatic drive_entry(entry_t e);
    clct_cand_t w;
    pend_t      p;
    w = e.mask[e.eg] ? clct_cand_t'('0) : e.cand[e.eg];
    p.ev         = e.ev;
    p.due        = cyc + 2;
    p.exp.pat    = w.pat;
    p.exp.key    = e.ek;
    p.exp.subkey = e.es;
    p.exp.qlt    = w.qlt;
    p.exp.bend   = w.bend;
    p.exp.carry  = w.carry;
    pend_q.push_back(p);
    cand_valid = 1'b1;
    cand       = e.cand;
    group_mask = e.mask;
  endtask

  // ------------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------------

  initial
  begin
    int i;
    seed       = 32'hb08a;
    rst        = 1'b1;
    cand_valid = 1'b0;
    cand       = '0;
    group_mask = '0;
    cyc        = '0;
    build_table();
    add_random_entries(24);
    repeat (10) next_cycle();
    rst = 1'b0;
    next_cycle();
    i = 0;
    while (i < tbl.size())
    begin
      // rows flagged b2b follow on the very next cycle
      do
      begin
        drive_entry(tbl[i]);
        next_cycle();
        i++;
      end
      while (i < tbl.size() && tbl[i].b2b);
      cand_valid = 1'b0;
      wait_results();
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
source/clct_pkg.sv
source/clct_cand_capture.sv
source/best_1of5_cclut.sv
source/clct_best_out.sv
source/clct_best_top.sv
tb/clct_best_assert.sv
tb/tb_clct_best.sv

// ==== Bender.yml ====
package:
  name: clct_best

sources:
  - source/clct_pkg.sv
  - source/clct_cand_capture.sv
  - source/best_1of5_cclut.sv
  - source/clct_best_out.sv
  - source/clct_best_top.sv
  - target: test
    files:
      - tb/clct_best_assert.sv
      - tb/tb_clct_best.sv
